// ==== verilog/clint_pkg.sv ====
// Hart count, bus widths, register map offsets and the operation and slave state enums for the CLINT
package clint_pkg;

    // Number of harts served by this CLINT
    localparam int CLINT_HARTS = 4;

    // Wishbone classic port geometry
    localparam int WB_ADDR_BITS = 16;
    localparam int WB_DATA_BITS = 32;
    localparam int WB_SEL_BITS  = 4;

    // Width of a hart index on the internal register port
    localparam int HART_IDX_BITS = 2;

    // Register map, byte offsets within the CLINT window
    localparam logic [WB_ADDR_BITS-1:0] MSIP_BASE     = 16'h0000;
    localparam logic [WB_ADDR_BITS-1:0] MTIMECMP_BASE = 16'h4000;
    localparam logic [WB_ADDR_BITS-1:0] MTIME_LO_ADDR = 16'hBFF8;
    localparam logic [WB_ADDR_BITS-1:0] MTIME_HI_ADDR = 16'hBFFC;

    // Register operation produced by the address decoder
    typedef enum logic [2:0] {
        OP_NONE        = 3'd0,
        OP_MSIP        = 3'd1,
        OP_MTIMECMP_LO = 3'd2,
        OP_MTIMECMP_HI = 3'd3,
        OP_MTIME_LO    = 3'd4,
        OP_MTIME_HI    = 3'd5
    } clint_op_e;

    // Wishbone slave states
    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_ACK  = 1'b1
    } wb_state_e;

endpackage

// ==== verilog/clint_bus_decode.sv ====
// Wishbone classic slave with CLINT address decode, ack generation and the read data register
`timescale 1ns/1ns

module clint_bus_decode (
    input  logic                                 clk,
    input  logic                                 nrst,
    input  logic                                 i_wb_cyc,
    input  logic                                 i_wb_stb,
    input  logic                                 i_wb_we,
    input  logic [clint_pkg::WB_ADDR_BITS-1:0]   i_wb_adr,
    input  logic [clint_pkg::WB_DATA_BITS-1:0]   i_wb_dat,
    input  logic [clint_pkg::WB_SEL_BITS-1:0]    i_wb_sel,
    input  logic [clint_pkg::WB_DATA_BITS-1:0]   i_rdata,
    output logic                                 o_wb_ack,
    output logic [clint_pkg::WB_DATA_BITS-1:0]   o_wb_dat,
    output logic                                 o_valid,
    output clint_pkg::clint_op_e                 o_op,
    output logic [clint_pkg::HART_IDX_BITS-1:0]  o_hart,
    output logic                                 o_write,
    output logic [clint_pkg::WB_DATA_BITS-1:0]   o_wdata,
    output logic [clint_pkg::WB_SEL_BITS-1:0]    o_sel
);
    import clint_pkg::*;

    wb_state_e               state;
    wb_state_e               state_nxt;
    logic                    accept;
    logic [WB_ADDR_BITS-1:0] word_adr;
    logic [WB_ADDR_BITS-1:0] msip_off;
    logic [WB_ADDR_BITS-1:0] cmp_off;

    // A new cycle is only taken while idle, so stb during the ack cycle is ignored
    assign accept = (state == WB_IDLE) && i_wb_cyc && i_wb_stb;

    always_comb begin
        state_nxt = state;
        case (state)
            WB_IDLE: begin
                if (accept) begin
                    state_nxt = WB_ACK;
                end
            end
            WB_ACK: begin
                state_nxt = WB_IDLE;
            end
            default: begin
                state_nxt = WB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Ack is high for exactly the cycle after acceptance
    assign o_wb_ack = (state == WB_ACK);

    // Read data is sampled at the accepting edge, same edge as the write
    always_ff @(posedge clk) begin
        if (accept) begin
            o_wb_dat <= i_rdata;
        end
    end

    // Byte offset bits are dropped, every register is word aligned
    assign word_adr = {i_wb_adr[WB_ADDR_BITS-1:2], 2'b00};

    // Offsets wrap below their base, which keeps those addresses out of range
    assign msip_off = word_adr - MSIP_BASE;
    assign cmp_off  = word_adr - MTIMECMP_BASE;

    always_comb begin
        o_op   = OP_NONE;
        o_hart = '0;
        if (word_adr == MTIME_LO_ADDR) begin
            o_op = OP_MTIME_LO;
        end else if (word_adr == MTIME_HI_ADDR) begin
            o_op = OP_MTIME_HI;
        end else if (cmp_off < WB_ADDR_BITS'(8 * CLINT_HARTS)) begin
            // Each hart owns eight bytes, low word first
            o_hart = cmp_off[HART_IDX_BITS+2:3];
            if (cmp_off[2]) begin
                o_op = OP_MTIMECMP_HI;
            end else begin
                o_op = OP_MTIMECMP_LO;
            end
        end else if (msip_off < WB_ADDR_BITS'(4 * CLINT_HARTS)) begin
            o_op   = OP_MSIP;
            o_hart = msip_off[HART_IDX_BITS+1:2];
        end
    end

    // Register port strobe and write payload
    assign o_valid = accept;
    assign o_write = i_wb_we;
    assign o_wdata = i_wb_dat;
    assign o_sel   = i_wb_sel;

endmodule

// ==== verilog/clint_regs.sv ====
// CLINT register file with msip bits, per-hart mtimecmp, the mtime counter and the read multiplexer
`timescale 1ns/1ns

module clint_regs (
    input  logic                                    clk,
    input  logic                                    nrst,
    input  logic                                    i_valid,
    input  clint_pkg::clint_op_e                    i_op,
    input  logic [clint_pkg::HART_IDX_BITS-1:0]     i_hart,
    input  logic                                    i_write,
    input  logic [clint_pkg::WB_DATA_BITS-1:0]      i_wdata,
    input  logic [clint_pkg::WB_SEL_BITS-1:0]       i_sel,
    output logic [clint_pkg::WB_DATA_BITS-1:0]      o_rdata,
    output logic [63:0]                             o_mtime,
    output logic [clint_pkg::CLINT_HARTS*64-1:0]    o_mtimecmp,
    output logic [clint_pkg::CLINT_HARTS-1:0]       o_msip
);
    import clint_pkg::*;

    logic [CLINT_HARTS-1:0] msip;
    logic [63:0]            mtimecmp [CLINT_HARTS];
    logic [63:0]            mtime;
    logic                   wr_en;

    assign wr_en = i_valid && i_write;

    // Free-running machine timer, read only from the bus
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // Software interrupt bits, only byte lane 0 carries the bit
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            msip <= '0;
        end else if (wr_en && (i_op == OP_MSIP) && i_sel[0]) begin
            msip[i_hart] <= i_wdata[0];
        end
    end

    // Compare registers are written a byte lane at a time within the addressed half
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int h = 0; h < CLINT_HARTS; h++) begin
                mtimecmp[h] <= '0;
            end
        end else if (wr_en) begin
            case (i_op)
                OP_MTIMECMP_LO: begin
                    for (int b = 0; b < WB_SEL_BITS; b++) begin
                        if (i_sel[b]) begin
                            mtimecmp[i_hart][8*b +: 8] <= i_wdata[8*b +: 8];
                        end
                    end
                end
                OP_MTIMECMP_HI: begin
                    for (int b = 0; b < WB_SEL_BITS; b++) begin
                        if (i_sel[b]) begin
                            mtimecmp[i_hart][32 + 8*b +: 8] <= i_wdata[8*b +: 8];
                        end
                    end
                end
                default: begin
                    // mtime and unmapped writes are dropped
                end
            endcase
        end
    end

    // Read data for the current operation, consumed by the decoder at acceptance
    always_comb begin
        o_rdata = '0;
        case (i_op)
            OP_MSIP: begin
                o_rdata[0] = msip[i_hart];
            end
            OP_MTIMECMP_LO: begin
                o_rdata = mtimecmp[i_hart][31:0];
            end
            OP_MTIMECMP_HI: begin
                o_rdata = mtimecmp[i_hart][63:32];
            end
            OP_MTIME_LO: begin
                o_rdata = mtime[31:0];
            end
            OP_MTIME_HI: begin
                o_rdata = mtime[63:32];
            end
            default: begin
                o_rdata = '0;
            end
        endcase
    end

    // Flatten the compare array for the interrupt block, hart 0 in the low bits
    always_comb begin
        for (int h = 0; h < CLINT_HARTS; h++) begin
            o_mtimecmp[64*h +: 64] = mtimecmp[h];
        end
    end

    assign o_mtime = mtime;
    assign o_msip  = msip;

endmodule

// ==== verilog/clint_timer_irq.sv ====
// Per-hart timer interrupt generation comparing mtime against each mtimecmp
`timescale 1ns/1ns

module clint_timer_irq (
    input  logic                                  clk,
    input  logic                                  nrst,
    input  logic [63:0]                           i_mtime,
    input  logic [clint_pkg::CLINT_HARTS*64-1:0]  i_mtimecmp,
    output logic [clint_pkg::CLINT_HARTS-1:0]     o_mtip
);
    import clint_pkg::*;

    logic [CLINT_HARTS-1:0] hit;

    // Unsigned compare, pending while the timer is at or past the compare value
    always_comb begin
        for (int h = 0; h < CLINT_HARTS; h++) begin
            hit[h] = (i_mtime >= i_mtimecmp[64*h +: 64]);
        end
    end

    // One cycle of latency from the compare to the hart
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            o_mtip <= '0;
        end else begin
            o_mtip <= hit;
        end
    end

endmodule

// ==== verilog/clint_top.sv ====
// CLINT top level joining the Wishbone decoder, the register file and the timer interrupt logic
`timescale 1ns/1ns

module clint_top (
    input  logic                                 clk,
    input  logic                                 nrst,
    input  logic                                 i_wb_cyc,
    input  logic                                 i_wb_stb,
    input  logic                                 i_wb_we,
    input  logic [clint_pkg::WB_ADDR_BITS-1:0]   i_wb_adr,
    input  logic [clint_pkg::WB_DATA_BITS-1:0]   i_wb_dat,
    input  logic [clint_pkg::WB_SEL_BITS-1:0]    i_wb_sel,
    output logic                                 o_wb_ack,
    output logic [clint_pkg::WB_DATA_BITS-1:0]   o_wb_dat,
    output logic [63:0]                          o_mtime,
    output logic [clint_pkg::CLINT_HARTS-1:0]    o_msip,
    output logic [clint_pkg::CLINT_HARTS-1:0]    o_mtip
);
    import clint_pkg::*;

    // Register port between decoder and register file
    logic                      reg_valid;
    clint_op_e                 reg_op;
    logic [HART_IDX_BITS-1:0]  reg_hart;
    logic                      reg_write;
    logic [WB_DATA_BITS-1:0]   reg_wdata;
    logic [WB_SEL_BITS-1:0]    reg_sel;
    logic [WB_DATA_BITS-1:0]   reg_rdata;

    // Timer state towards the interrupt block
    logic [CLINT_HARTS*64-1:0] mtimecmp_flat;

    clint_bus_decode u_decode (
        .clk      (clk),
        .nrst     (nrst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .i_wb_sel (i_wb_sel),
        .i_rdata  (reg_rdata),
        .o_wb_ack (o_wb_ack),
        .o_wb_dat (o_wb_dat),
        .o_valid  (reg_valid),
        .o_op     (reg_op),
        .o_hart   (reg_hart),
        .o_write  (reg_write),
        .o_wdata  (reg_wdata),
        .o_sel    (reg_sel)
    );

    clint_regs u_regs (
        .clk        (clk),
        .nrst       (nrst),
        .i_valid    (reg_valid),
        .i_op       (reg_op),
        .i_hart     (reg_hart),
        .i_write    (reg_write),
        .i_wdata    (reg_wdata),
        .i_sel      (reg_sel),
        .o_rdata    (reg_rdata),
        .o_mtime    (o_mtime),
        .o_mtimecmp (mtimecmp_flat),
        .o_msip     (o_msip)
    );

    clint_timer_irq u_timer_irq (
        .clk        (clk),
        .nrst       (nrst),
        .i_mtime    (o_mtime),
        .i_mtimecmp (mtimecmp_flat),
        .o_mtip     (o_mtip)
    );

endmodule

// ==== verification/clint_assertions.sv ====
// Wishbone classic handshake assertions for the CLINT bus slave
`timescale 1ns/1ns

module clint_assertions (
    input logic clk,
    input logic nrst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack
);

    // Number of assertion failures seen so far
    int unsigned error_count = 0;

    // Every access is answered by a single ack cycle
    ack_single_cycle: assert property (@(posedge clk) disable iff (!nrst)
        i_wb_ack |=> !i_wb_ack)
    else begin
        $error("wishbone ack was high for two cycles in a row");
        error_count++;
    end

    // Ack answers a cycle and strobe seen at the previous edge
    ack_after_strobe: assert property (@(posedge clk) disable iff (!nrst)
        i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else begin
        $error("wishbone ack without a preceding cycle and strobe");
        error_count++;
    end

    ack_low_after_reset: assert property (@(posedge clk) $rose(nrst) |-> !i_wb_ack)
    else begin
        $error("wishbone ack high in the first cycle after reset");
        error_count++;
    end

endmodule

// ==== verification/clint_tb.sv ====
// Testbench for the CLINT with Wishbone bus tasks, directed tests, timeout and final verdict
`timescale 1ns/1ns

module clint_tb;
    import clint_pkg::*;

    // Generous margin over the few hundred cycles the directed tests take
    localparam int          TIMEOUT_CYCLES = 5000;
    localparam logic [31:0] RAND_SEED      = 32'hefb0;

    logic                    clk;
    logic                    nrst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [WB_ADDR_BITS-1:0] wb_adr;
    logic [WB_DATA_BITS-1:0] wb_dat_w;
    logic [WB_SEL_BITS-1:0]  wb_sel;
    logic                    wb_ack;
    logic [WB_DATA_BITS-1:0] wb_dat_r;
    logic [63:0]             mtime;
    logic [CLINT_HARTS-1:0]  msip;
    logic [CLINT_HARTS-1:0]  mtip;
    int                      cycle_count = 0;

    // Expected register contents that follow every write the tests make
    logic [CLINT_HARTS-1:0]  msip_model;
    logic [63:0]             cmp_model [CLINT_HARTS];

    clint_top dut (
        .clk      (clk),
        .nrst     (nrst),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .i_wb_sel (wb_sel),
        .o_wb_ack (wb_ack),
        .o_wb_dat (wb_dat_r),
        .o_mtime  (mtime),
        .o_msip   (msip),
        .o_mtip   (mtip)
    );

    bind clint_bus_decode clint_assertions u_assertions (
        .clk      (clk),
        .nrst     (nrst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_ack (o_wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not complete within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped by the timeout");
    end

    function automatic logic [WB_ADDR_BITS-1:0] msip_addr(input int hart);
        return MSIP_BASE + WB_ADDR_BITS'(4 * hart);
    endfunction

    // Each hart owns eight bytes of compare register with the low word first
    function automatic logic [WB_ADDR_BITS-1:0] cmp_addr(input int hart, input int half);
        return MTIMECMP_BASE + WB_ADDR_BITS'(8 * hart + 4 * half);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < WB_SEL_BITS; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // mtip shows the compare of the previous cycle, when mtime was one lower
    function automatic logic mtip_expected(input int hart);
        return (mtime - 64'd1) >= cmp_model[hart];
    endfunction

    task automatic stop_with_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
        assert (got === exp)
        else stop_with_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic wait_ack();
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
    endtask

    task automatic wb_write(input logic [WB_ADDR_BITS-1:0] addr,
                            input logic [31:0] data, input logic [3:0] sel);
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        wb_sel   = sel;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [WB_ADDR_BITS-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wb_sel = 4'hf;
        wait_ack();
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic write_cmp_half(input int hart, input int half,
                                  input logic [31:0] data, input logic [3:0] sel);
        cmp_model[hart][32*half +: 32] = merge_bytes(cmp_model[hart][32*half +: 32], data, sel);
        wb_write(cmp_addr(hart, half), data, sel);
    endtask

    task automatic check_cmp(input int hart);
        logic [31:0] lo;
        logic [31:0] hi;
        wb_read(cmp_addr(hart, 0), lo);
        wb_read(cmp_addr(hart, 1), hi);
        expect_equal({hi, lo}, cmp_model[hart], $sformatf("mtimecmp of hart %0d", hart));
    endtask

    task automatic check_other_mtip(input int skip);
        for (int h = 0; h < CLINT_HARTS; h++) begin
            if (h != skip) begin
                expect_equal(64'(mtip[h]), 64'(mtip_expected(h)), $sformatf("mtip of hart %0d", h));
            end
        end
    endtask

    task automatic test_reset_state();
        expect_equal(64'(wb_ack), 64'd0, "ack after reset");
        expect_equal(64'(msip), 64'd0, "msip after reset");
        for (int h = 0; h < CLINT_HARTS; h++) begin
            check_cmp(h);
        end
        // Every compare value is zero, so every hart is pending
        expect_equal(64'(mtip), 64'({CLINT_HARTS{1'b1}}), "mtip after reset");
    endtask

    task automatic test_msip();
        logic [31:0] data;
        logic [31:0] rd;
        logic [3:0]  sel;
        for (int h = 0; h < CLINT_HARTS; h++) begin
            data = $urandom;
            sel  = 4'($urandom) | 4'b0001;
            wb_write(msip_addr(h), data, sel);
            msip_model[h] = data[0];
            expect_equal(64'(msip), 64'(msip_model), "msip outputs");
            wb_read(msip_addr(h), rd);
            expect_equal(64'(rd), 64'(msip_model[h]), $sformatf("msip read of hart %0d", h));
            // With lane 0 left out the bit must hold
            sel = 4'($urandom) & 4'b1110;
            wb_write(msip_addr(h), ~data, sel);
            wb_read(msip_addr(h), rd);
            expect_equal(64'(rd), 64'(msip_model[h]), $sformatf("msip of hart %0d", h));
        end
        expect_equal(64'(msip), 64'(msip_model), "msip outputs");
    endtask

    task automatic test_mtimecmp_bytes();
        int hart;
        for (int h = 0; h < CLINT_HARTS; h++) begin
            write_cmp_half(h, 0, $urandom, 4'hf);
            write_cmp_half(h, 1, $urandom, 4'hf);
            check_cmp(h);
        end
        for (int n = 0; n < 16; n++) begin
            hart = $urandom % CLINT_HARTS;
            write_cmp_half(hart, $urandom % 2, $urandom, 4'($urandom));
            check_cmp(hart);
        end
    endtask

    task automatic test_mtime();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] third;
        logic [31:0] hi;
        logic [63:0] lag;
        wb_read(MTIME_LO_ADDR, first);
        lag = mtime - {32'd0, first};
        assert (lag >= 64'd1 && lag <= 64'd2)
        else stop_with_error($sformatf("mtime read %h lags o_mtime by %0d", first, lag));
        repeat (10) @(posedge clk);
        wb_read(MTIME_LO_ADDR, second);
        assert (second > first)
        else stop_with_error($sformatf("mtime read %h after %h", second, first));
        // The timer started at zero and the timeout keeps the run far below 2**32 cycles
        wb_read(MTIME_HI_ADDR, hi);
        expect_equal(64'(hi), 64'd0, "mtime high word");
        wb_write(MTIME_LO_ADDR, 32'd0, 4'hf);
        wb_write(MTIME_HI_ADDR, 32'd0, 4'hf);
        wb_read(MTIME_LO_ADDR, third);
        assert (third > second)
        else stop_with_error($sformatf("mtime read %h after a write, earlier %h", third, second));
    endtask

    task automatic test_timer_irq();
        int          hart;
        int          waited;
        logic [63:0] target;
        hart = $urandom % CLINT_HARTS;
        write_cmp_half(hart, 0, 32'hffff_ffff, 4'hf);
        write_cmp_half(hart, 1, 32'hffff_ffff, 4'hf);
        waited = 0;
        while (mtip[hart] && waited < 3) begin
            @(posedge clk);
            #1;
            waited++;
        end
        repeat (10) begin
            assert (!mtip[hart])
            else stop_with_error("mtip is high with mtimecmp at its maximum");
            check_other_mtip(hart);
            @(posedge clk);
            #1;
        end
        // Writing the low half first keeps the compare value above mtime until the high half lands
        target = mtime + 64'd40;
        write_cmp_half(hart, 0, target[31:0], 4'hf);
        write_cmp_half(hart, 1, target[63:32], 4'hf);
        while (mtime < target) begin
            assert (!mtip[hart])
            else stop_with_error("mtip rose before mtime reached mtimecmp");
            check_other_mtip(hart);
            @(posedge clk);
            #1;
        end
        waited = 0;
        while (!mtip[hart] && waited < 2) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (mtip[hart])
        else stop_with_error("mtip did not rise within two cycles of mtime reaching mtimecmp");
        check_other_mtip(hart);
    endtask

    task automatic test_unmapped();
        logic [WB_ADDR_BITS-1:0] addrs [3];
        logic [31:0]             rd;
        addrs[0] = 16'h2000;
        addrs[1] = msip_addr(CLINT_HARTS);
        addrs[2] = cmp_addr(CLINT_HARTS, 0);
        for (int i = 0; i < 3; i++) begin
            wb_write(addrs[i], 32'hffff_ffff, 4'hf);
            wb_read(addrs[i], rd);
            expect_equal(64'(rd), 64'd0, $sformatf("read of unmapped address %h", addrs[i]));
        end
        expect_equal(64'(msip), 64'(msip_model), "msip after unmapped writes");
        for (int h = 0; h < CLINT_HARTS; h++) begin
            check_cmp(h);
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        nrst     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        msip_model = '0;
        for (int h = 0; h < CLINT_HARTS; h++) begin
            cmp_model[h] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        nrst = 1'b1;
        test_reset_state();
        test_msip();
        test_mtimecmp_bytes();
        test_mtime();
        test_timer_irq();
        test_unmapped();
        if (dut.u_decode.u_assertions.error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("Bus protocol assertions failed during the run");
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== clint_top.f ====
verilog/clint_pkg.sv
verilog/clint_bus_decode.sv
verilog/clint_regs.sv
verilog/clint_timer_irq.sv
verilog/clint_top.sv
verification/clint_assertions.sv
verification/clint_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CLINT testbench with Verilator, run it and look for the pass line in its output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module clint_tb \
        -f clint_top.f --Mdir obj_dir -o clint_sim \
    && ./obj_dir/clint_sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
    && echo "clint simulation passed" \
    || { echo "clint simulation failed"; exit 1; }
